/* common/fetch_pkg.sv */
package fetch_pkg;

    // widths with a meaning of their own
    typedef logic [63:0] pc_t;
    typedef logic [31:0] inst_t;
    // instruction memory address, the low bits of the pc
    typedef logic [31:0] mem_addr_t;
    // one read data beat, two instructions
    typedef logic [63:0] mem_data_t;
    typedef logic [4:0]  reg_idx_t;

    // coarse instruction class from the predecoder
    typedef enum logic [2:0] {
        class_alu,
        class_load,
        class_store,
        class_branch,
        class_jal,
        class_jalr,
        class_system,
        class_illegal
    } inst_class_e;

    // major opcodes, inst[6:0]
    // alu group
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    // memory access
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    // control transfer
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    // ecall, ebreak, csr access
    localparam logic [6:0] opc_system = 7'b1110011;

    // ebreak, full word
    localparam inst_t inst_ebreak = 32'h0010_0073;

endpackage

/* ifu/ifu_fetch.sv */
`timescale 1ns/1ps

module ifu_fetch #(
    parameter fetch_pkg::pc_t RESET_PC = 64'h0000_0000_8000_0000,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 arst_n,
    // axi4-lite read address channel
    output fetch_pkg::mem_addr_t araddr,
    output logic                 arvalid,
    input  logic                 arready,
    // axi4-lite read data channel
    input  fetch_pkg::mem_data_t rdata,
    input  logic [1:0]           rresp,
    input  logic                 rvalid,
    output logic                 rready,
    // redirect from execute
    input  logic                 redirect_valid,
    input  fetch_pkg::pc_t       redirect_pc,
    // redirect and stop from the predecoder
    input  logic                 jal_redirect_valid,
    input  fetch_pkg::pc_t       jal_redirect_pc,
    input  logic                 halt,
    // fetch queue
    output logic                 push_valid,
    output fetch_pkg::pc_t       push_pc,
    output fetch_pkg::inst_t     push_inst,
    input  logic                 pop_fire,
    output logic                 flush
);

    localparam int cnt_w = $clog2(QUEUE_DEPTH) + 1;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_resp,
        st_halted
    } fetch_state_e;

    fetch_state_e     state;
    fetch_state_e     state_d;
    fetch_pkg::pc_t   pc;
    fetch_pkg::pc_t   req_pc;
    fetch_pkg::inst_t rd_half;
    logic             epoch;
    logic             req_epoch;
    logic             halt_pend;
    logic             halt_pend_d;
    logic [cnt_w-1:0] credits;
    logic             ar_fire;
    logic             r_fire;
    logic             ext_take;
    logic             jal_take;
    logic             halt_take;
    logic             kill;
    logic             resp_stale;
    logic             drop_fire;
    logic             launch;
    logic             stop_next;
    logic             outstanding_d;

    // one read in flight at most
    assign arvalid = (state == st_addr);
    assign rready  = (state == st_resp);
    // address held in req_pc so it stays stable while arvalid is up
    assign araddr  = fetch_pkg::mem_addr_t'(req_pc);

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // execute redirect beats everything
    assign ext_take  = redirect_valid;
    assign halt_take = halt && !redirect_valid;
    // jal redirect is ignored once an ebreak has stopped fetch
    assign jal_take  = jal_redirect_valid && !redirect_valid && !halt
                     && (state != st_halted) && !halt_pend;
    assign flush = ext_take || jal_take;
    assign kill  = flush || halt_take;

    // request launched under an older epoch
    assign resp_stale = (req_epoch != epoch);

    // upper word when pc bit 2 is set
    // bus error gives an all-zero word, which decodes as illegal
    assign rd_half = req_pc[2] ? rdata[63:32] : rdata[31:0];

    assign push_valid = r_fire && !resp_stale && !kill;
    assign push_pc    = req_pc;
    assign push_inst  = (rresp == 2'b00) ? rd_half : '0;
    // dropped beats hand their slot back
    assign drop_fire  = r_fire && !push_valid;

    // new request only with a free, unclaimed slot
    assign launch = (state == st_idle) && (credits != '0) && !kill;

    // halt wins unless a redirect clears it this cycle
    assign stop_next     = halt_take || (halt_pend && !redirect_valid);
    assign outstanding_d = (state == st_addr) || ((state == st_resp) && !r_fire);
    assign halt_pend_d   = stop_next && outstanding_d;

    always_comb begin
        state_d = state;
        case (state)
            st_idle: begin
                if (halt_take) begin
                    state_d = st_halted;
                end else if (launch) begin
                    state_d = st_addr;
                end
            end
            st_addr: begin
                if (ar_fire) begin
                    state_d = st_resp;
                end
            end
            st_resp: begin
                // finish the beat first, stop after it
                if (r_fire) begin
                    state_d = stop_next ? st_halted : st_idle;
                end
            end
            st_halted: begin
                if (ext_take) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            pc        <= RESET_PC;
            epoch     <= 1'b0;
            req_epoch <= 1'b0;
            halt_pend <= 1'b0;
            credits   <= cnt_w'(QUEUE_DEPTH);
        end else begin
            state     <= state_d;
            halt_pend <= halt_pend_d;
            // toggle once per request, a second kill must not revive it
            if (kill && !resp_stale) begin
                epoch <= ~epoch;
            end
            if (launch) begin
                req_epoch <= epoch;
            end
            if (ext_take) begin
                pc <= redirect_pc;
            end else if (jal_take) begin
                pc <= jal_redirect_pc;
            end else if (launch) begin
                pc <= pc + 64'd4;
            end
            // queue empties on flush, only a pending read keeps its claim
            if (flush) begin
                credits <= cnt_w'(QUEUE_DEPTH) - cnt_w'(outstanding_d);
            end else begin
                credits <= credits + cnt_w'(pop_fire) + cnt_w'(drop_fire)
                         - cnt_w'(launch);
            end
        end
    end

    // request pc, captured at launch
    always_ff @(posedge clk) begin
        if (launch) begin
            req_pc <= pc;
        end
    end

endmodule

/* hw/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    // write side has no ready since the fetch unit counts credits
    input  logic             push_valid,
    input  fetch_pkg::pc_t   push_pc,
    input  fetch_pkg::inst_t push_inst,
    // read side
    output logic             pop_valid,
    output fetch_pkg::pc_t   pop_pc,
    output fetch_pkg::inst_t pop_inst,
    input  logic             pop_ready
);

    localparam int idx_w = $clog2(QUEUE_DEPTH);

    // storage holds pc and word side by side
    fetch_pkg::pc_t   pc_mem   [QUEUE_DEPTH];
    fetch_pkg::inst_t inst_mem [QUEUE_DEPTH];

    // extra msb tells full from empty
    logic [idx_w:0] wr_ptr;
    logic [idx_w:0] rd_ptr;
    logic           push_fire;
    logic           pop_fire;

    assign pop_valid = (wr_ptr != rd_ptr);
    assign pop_pc    = pc_mem[rd_ptr[idx_w-1:0]];
    assign pop_inst  = inst_mem[rd_ptr[idx_w-1:0]];

    // flush drops a push in the same cycle
    assign push_fire = push_valid && !flush;
    assign pop_fire  = pop_valid && pop_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            // both pointers back to zero so the queue is empty next cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= wr_ptr + (idx_w + 1)'(1);
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + (idx_w + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            pc_mem[wr_ptr[idx_w-1:0]]   <= push_pc;
            inst_mem[wr_ptr[idx_w-1:0]] <= push_inst;
        end
    end

endmodule

/* hw/predecode.sv */
`timescale 1ns/1ps

module predecode (
    input  logic                   clk,
    input  logic                   arst_n,
    // from the fetch queue
    input  logic                   pop_valid,
    input  fetch_pkg::pc_t         pop_pc,
    input  fetch_pkg::inst_t       pop_inst,
    output logic                   pop_ready,
    // decoded output
    output logic                   dec_valid,
    output fetch_pkg::pc_t         dec_pc,
    output fetch_pkg::inst_t       dec_inst,
    output fetch_pkg::inst_class_e dec_class,
    output fetch_pkg::reg_idx_t    dec_rd,
    output fetch_pkg::reg_idx_t    dec_rs1,
    output fetch_pkg::reg_idx_t    dec_rs2,
    input  logic                   dec_ready,
    // redirect from execute
    input  logic                   redirect_valid,
    // to the fetch unit
    output logic                   jal_redirect_valid,
    output fetch_pkg::pc_t         jal_redirect_pc,
    output logic                   halt
);

    fetch_pkg::inst_class_e cls;
    fetch_pkg::pc_t         imm_j;
    logic [6:0]             opcode;
    logic                   pop_fire;

    assign opcode = pop_inst[6:0];

    // opcode to class
    always_comb begin
        case (opcode)
            fetch_pkg::opc_op,
            fetch_pkg::opc_op_imm,
            fetch_pkg::opc_lui,
            fetch_pkg::opc_auipc:  cls = fetch_pkg::class_alu;
            fetch_pkg::opc_load:   cls = fetch_pkg::class_load;
            fetch_pkg::opc_store:  cls = fetch_pkg::class_store;
            fetch_pkg::opc_branch: cls = fetch_pkg::class_branch;
            fetch_pkg::opc_jal:    cls = fetch_pkg::class_jal;
            fetch_pkg::opc_jalr:   cls = fetch_pkg::class_jalr;
            fetch_pkg::opc_system: cls = fetch_pkg::class_system;
            default:               cls = fetch_pkg::class_illegal;
        endcase
    end

    // j immediate, sign extended, bit 0 always zero
    assign imm_j = {{44{pop_inst[31]}}, pop_inst[19:12], pop_inst[20],
                    pop_inst[30:21], 1'b0};

    // take a new entry when the output slot frees up
    // blocked during any redirect so wrong-path entries stay in the queue
    assign pop_ready = (!dec_valid || dec_ready) && !redirect_valid
                     && !jal_redirect_valid;
    assign pop_fire  = pop_valid && pop_ready;

    // stop fetch as the ebreak leaves
    assign halt = dec_valid && dec_ready && (dec_inst == fetch_pkg::inst_ebreak);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid          <= 1'b0;
            jal_redirect_valid <= 1'b0;
        end else begin
            // execute redirect kills the held entry
            if (redirect_valid) begin
                dec_valid <= 1'b0;
            end else if (pop_fire) begin
                dec_valid <= 1'b1;
            end else if (dec_ready) begin
                dec_valid <= 1'b0;
            end
            // pop_fire is already low under redirect_valid, jal redirect dropped then
            jal_redirect_valid <= pop_fire && (cls == fetch_pkg::class_jal);
        end
    end

    // output payload, loaded on pop
    always_ff @(posedge clk) begin
        if (pop_fire) begin
            dec_pc          <= pop_pc;
            dec_inst        <= pop_inst;
            dec_class       <= cls;
            dec_rd          <= pop_inst[11:7];
            dec_rs1         <= pop_inst[19:15];
            dec_rs2         <= pop_inst[24:20];
            jal_redirect_pc <= pop_pc + imm_j;
        end
    end

endmodule

/* hw/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top #(
    parameter fetch_pkg::pc_t RESET_PC = 64'h0000_0000_8000_0000,
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // axi4-lite read, instruction memory
    output fetch_pkg::mem_addr_t   araddr,
    output logic                   arvalid,
    input  logic                   arready,
    input  fetch_pkg::mem_data_t   rdata,
    input  logic [1:0]             rresp,
    input  logic                   rvalid,
    output logic                   rready,
    // redirect from execute
    input  logic                   redirect_valid,
    input  fetch_pkg::pc_t         redirect_pc,
    // decoded output
    output logic                   dec_valid,
    output fetch_pkg::pc_t         dec_pc,
    output fetch_pkg::inst_t       dec_inst,
    output fetch_pkg::inst_class_e dec_class,
    output fetch_pkg::reg_idx_t    dec_rd,
    output fetch_pkg::reg_idx_t    dec_rs1,
    output fetch_pkg::reg_idx_t    dec_rs2,
    input  logic                   dec_ready
);

    // fetch to queue
    logic             push_valid;
    fetch_pkg::pc_t   push_pc;
    fetch_pkg::inst_t push_inst;
    logic             flush;
    // queue to predecode
    logic             pop_valid;
    fetch_pkg::pc_t   pop_pc;
    fetch_pkg::inst_t pop_inst;
    logic             pop_ready;
    logic             pop_fire;
    // predecode back to fetch
    logic             jal_redirect_valid;
    fetch_pkg::pc_t   jal_redirect_pc;
    logic             halt;

    // credit return for the fetch unit
    assign pop_fire = pop_valid && pop_ready;

    ifu_fetch #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_ifu_fetch (
        .clk, .arst_n,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .redirect_valid, .redirect_pc,
        .jal_redirect_valid, .jal_redirect_pc, .halt,
        .push_valid, .push_pc, .push_inst,
        .pop_fire, .flush
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk, .arst_n, .flush,
        .push_valid, .push_pc, .push_inst,
        .pop_valid, .pop_pc, .pop_inst, .pop_ready
    );

    predecode u_predecode (
        .clk, .arst_n,
        .pop_valid, .pop_pc, .pop_inst, .pop_ready,
        .dec_valid, .dec_pc, .dec_inst, .dec_class,
        .dec_rd, .dec_rs1, .dec_rs2, .dec_ready,
        .redirect_valid,
        .jal_redirect_valid, .jal_redirect_pc, .halt
    );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns    = 8.0,
    parameter int  reset_cycles = 16
) (
    output logic clk,
    output logic arst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // reset held low, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

/* test/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend;

    localparam fetch_pkg::pc_t reset_pc = 64'h0000_0000_8000_0000;
    localparam int queue_depth  = 4;
    localparam int reset_cycles = 16;
    // outputs per test in run order
    localparam int total_outputs = 16 + 64 + 24 + 10 + 11 + 12;

    logic                   clk;
    logic                   arst_n;
    fetch_pkg::mem_addr_t   araddr;
    logic                   arvalid;
    logic                   arready;
    fetch_pkg::mem_data_t   rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    logic                   redirect_valid;
    fetch_pkg::pc_t         redirect_pc;
    logic                   dec_valid;
    fetch_pkg::pc_t         dec_pc;
    fetch_pkg::inst_t       dec_inst;
    fetch_pkg::inst_class_e dec_class;
    fetch_pkg::reg_idx_t    dec_rd;
    fetch_pkg::reg_idx_t    dec_rs1;
    fetch_pkg::reg_idx_t    dec_rs2;
    logic                   dec_ready;

    int             seed = 67384;
    int             errors = 0;
    int             n_outputs = 0;
    // next pc the output stream must show
    fetch_pkg::pc_t exp_pc = reset_pc;
    // words that replace the default fill
    fetch_pkg::inst_t ovr [fetch_pkg::mem_addr_t];
    // jump offsets of the jal words placed in the table
    fetch_pkg::pc_t   jal_off [fetch_pkg::mem_addr_t];

    tb_clk_gen #(.period_ns(8.0), .reset_cycles(reset_cycles)) u_clk_gen (.clk, .arst_n);

    frontend_top #(
        .RESET_PC    (reset_pc),
        .QUEUE_DEPTH (queue_depth)
    ) u_frontend_top (
        .clk, .arst_n,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .redirect_valid, .redirect_pc,
        .dec_valid, .dec_pc, .dec_inst, .dec_class,
        .dec_rd, .dec_rs1, .dec_rs2, .dec_ready
    );

    // addi with rd and rs1 from low address bits and immediate from the upper ones
    function automatic fetch_pkg::inst_t default_word(input fetch_pkg::mem_addr_t a);
        logic [11:0] imm;
        imm = a[31:20] ^ {4'h0, a[19:12]};
        return {imm, a[11:7], 3'b000, a[6:2], fetch_pkg::opc_op_imm};
    endfunction

    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::mem_addr_t a);
        if (ovr.exists(a)) begin
            return ovr[a];
        end
        return default_word(a);
    endfunction

    // 64-bit beat with the lower address in the low half
    function automatic fetch_pkg::mem_data_t read_beat(input fetch_pkg::mem_addr_t a);
        fetch_pkg::mem_addr_t base;
        base = {a[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    function automatic fetch_pkg::inst_class_e class_of(input fetch_pkg::inst_t w);
        case (w[6:0])
            fetch_pkg::opc_op, fetch_pkg::opc_op_imm,
            fetch_pkg::opc_lui, fetch_pkg::opc_auipc: return fetch_pkg::class_alu;
            fetch_pkg::opc_load:   return fetch_pkg::class_load;
            fetch_pkg::opc_store:  return fetch_pkg::class_store;
            fetch_pkg::opc_branch: return fetch_pkg::class_branch;
            fetch_pkg::opc_jal:    return fetch_pkg::class_jal;
            fetch_pkg::opc_jalr:   return fetch_pkg::class_jalr;
            fetch_pkg::opc_system: return fetch_pkg::class_system;
            default:               return fetch_pkg::class_illegal;
        endcase
    endfunction

    function automatic fetch_pkg::inst_t enc_jal(input fetch_pkg::reg_idx_t rd,
                                                 input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, fetch_pkg::opc_jal};
    endfunction

    // r-type layout with distinct fields per slot
    function automatic fetch_pkg::inst_t enc_fields(input logic [6:0] opc, input int i);
        return {7'b0000000, 5'(2 * i + 1), 5'(i + 12), 3'b000, 5'(i + 3), opc};
    endfunction

    // jal word plus the offset it is meant to jump by
    task automatic place_jal(input fetch_pkg::mem_addr_t a, input fetch_pkg::reg_idx_t rd,
                             input logic [20:0] off);
        ovr[a]     = enc_jal(rd, off);
        jal_off[a] = {{43{off[20]}}, off};
    endtask

    task automatic load_table();
        logic [6:0] opcs [11];
        opcs = '{fetch_pkg::opc_op, fetch_pkg::opc_op_imm, fetch_pkg::opc_lui,
                 fetch_pkg::opc_auipc, fetch_pkg::opc_load, fetch_pkg::opc_store,
                 fetch_pkg::opc_branch, fetch_pkg::opc_jalr, fetch_pkg::opc_system,
                 7'b0001011, fetch_pkg::opc_jal};
        // forward jal and then a backward one from the target stream
        place_jal(32'h8000_3008, 5'd1, 21'd32);
        place_jal(32'h8000_3030, 5'd5, -21'sd72);
        // jal goes last so its target is never consumed
        for (int i = 0; i < 11; i++) begin
            ovr[32'h8000_4000 + 32'(4 * i)] = enc_fields(opcs[i], i);
        end
        ovr[32'h8000_500C] = fetch_pkg::inst_ebreak;
    endtask

    task automatic check_pc(input string name, input fetch_pkg::pc_t exp,
                            input fetch_pkg::pc_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: pc expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input fetch_pkg::inst_t exp,
                              input fetch_pkg::inst_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: inst expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_class(input string name, input fetch_pkg::inst_class_e exp,
                               input fetch_pkg::inst_class_e act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: class expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_reg(input string name, input string field,
                             input fetch_pkg::reg_idx_t exp, input fetch_pkg::reg_idx_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: %s expected %0d, actual %0d", name, field, exp, act);
        end
    endtask

    // one accepted output against the expected stream
    task automatic score_output(input string name);
        fetch_pkg::inst_t     w;
        fetch_pkg::mem_addr_t a;
        a = exp_pc[31:0];
        w = mem_word(a);
        check_pc(name, exp_pc, dec_pc);
        check_inst(name, w, dec_inst);
        check_class(name, class_of(w), dec_class);
        check_reg(name, "rd", w[11:7], dec_rd);
        check_reg(name, "rs1", w[19:15], dec_rs1);
        check_reg(name, "rs2", w[24:20], dec_rs2);
        if (jal_off.exists(a)) begin
            exp_pc = exp_pc + jal_off[a];
        end else begin
            exp_pc = exp_pc + 64'd4;
        end
        n_outputs++;
    endtask

    // accept n outputs and drop ready right after the last one
    task automatic run_outputs(input string name, input int n, input logic rnd_ready);
        logic next_ready;
        int   rnd;
        int   got;
        next_ready = 1'b1;
        got = 0;
        while (got < n) begin
            @(posedge clk);
            #1;
            dec_ready = next_ready;
            // handshake happens at the coming edge
            @(negedge clk);
            if (dec_valid && dec_ready) begin
                score_output(name);
                got++;
            end
            rnd = $random(seed);
            next_ready = rnd_ready ? rnd[0] : 1'b1;
        end
        @(posedge clk);
        #1;
        dec_ready = 1'b0;
    endtask

    // one-cycle pulse with the consumer not ready during it
    task automatic send_redirect(input fetch_pkg::pc_t target);
        @(posedge clk);
        #1;
        dec_ready      = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        exp_pc         = target;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
    endtask

    // a read already on the bus may finish but no new one may start
    task automatic watch_halted_bus(input string name, input int cycles);
        logic prev;
        prev = arvalid;
        repeat (cycles) begin
            @(negedge clk);
            if (arvalid && !prev) begin
                errors++;
                $display("%s: new read address issued while halted", name);
            end
            prev = arvalid;
        end
        if (arvalid) begin
            errors++;
            $display("%s: read address still raised at end of halt window", name);
        end
    endtask

    task automatic reset_fetch();
        // read address due in the first full cycle after release
        @(posedge clk);
        @(negedge clk);
        if (!arvalid) begin
            errors++;
            $display("reset_fetch: no read address in the first cycle after reset");
        end else begin
            check_pc("reset_fetch", reset_pc, fetch_pkg::pc_t'(araddr));
        end
        run_outputs("reset_fetch", 16, 1'b0);
    endtask

    task automatic backpressure();
        run_outputs("backpressure", 64, 1'b1);
    endtask

    task automatic ext_redirect();
        run_outputs("ext_redirect", 8, 1'b1);
        // odd word target starts in the high half
        send_redirect(64'h0000_0000_8000_2004);
        run_outputs("ext_redirect", 16, 1'b1);
    endtask

    task automatic jal_target();
        send_redirect(64'h0000_0000_8000_3000);
        run_outputs("jal_target", 10, 1'b1);
    endtask

    task automatic classify_all();
        send_redirect(64'h0000_0000_8000_4000);
        run_outputs("classify_all", 11, 1'b0);
    endtask

    task automatic ebreak_halt();
        send_redirect(64'h0000_0000_8000_5000);
        // fourth output is the ebreak
        run_outputs("ebreak_halt", 4, 1'b0);
        watch_halted_bus("ebreak_halt", 50);
        send_redirect(64'h0000_0000_8000_6000);
        run_outputs("ebreak_halt", 8, 1'b1);
    endtask

    // axi4-lite read slave with random delay on both channels
    initial begin : axi_slave
        logic                 ar_hs;
        logic                 r_hs;
        logic                 r_pend;
        fetch_pkg::mem_addr_t ar_addr_s;
        fetch_pkg::mem_addr_t rd_addr;
        int                   ar_wait;
        int                   r_wait;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        r_pend  = 1'b0;
        rd_addr = '0;
        r_wait  = 0;
        ar_wait = $random(seed) & 3;
        forever begin
            // handshakes of the coming edge
            @(negedge clk);
            ar_hs     = arvalid && arready;
            r_hs      = rvalid && rready;
            ar_addr_s = araddr;
            @(posedge clk);
            #1;
            if (r_hs) begin
                rvalid = 1'b0;
            end
            if (ar_hs) begin
                arready = 1'b0;
                rd_addr = ar_addr_s;
                r_pend  = 1'b1;
                r_wait  = $random(seed) & 3;
                ar_wait = $random(seed) & 3;
            end else if (arvalid && !arready) begin
                if (ar_wait == 0) begin
                    arready = 1'b1;
                end else begin
                    ar_wait = ar_wait - 1;
                end
            end
            if (r_pend && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = read_beat(rd_addr);
                    r_pend = 1'b0;
                end else begin
                    r_wait = r_wait - 1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (reset_cycles + 200 * total_outputs) @(posedge clk);
        $display("timeout: %0d of %0d outputs seen before the time limit",
                 n_outputs, total_outputs);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dec_ready      = 1'b0;
        load_table();
        @(negedge clk);
        if (arvalid || rready || dec_valid) begin
            errors++;
            $display("reset: bus or output active while reset is held");
        end
        @(posedge arst_n);
        reset_fetch();
        backpressure();
        ext_redirect();
        jal_target();
        classify_all();
        ebreak_halt();
        repeat (4) @(posedge clk);
        $display("errors: %0d, outputs checked: %0d", errors, n_outputs);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* ifu_frontend.f */
common/fetch_pkg.sv
ifu/ifu_fetch.sv
hw/fetch_queue.sv
hw/predecode.sv
hw/frontend_top.sv
test/tb_clk_gen.sv
test/tb_frontend.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_frontend
FILELIST = ifu_frontend.f

.PHONY: sim clean

# build, run, pass only if the pass line shows up
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
